// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tbCsrUnit
FILELIST = verilog.f
OBJDIR   = obj_dir
PASSMSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: csrOpLogic.sv
//////////////////////////////
// Set and clear with a zero source only read, whatever rs1 was.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csrOpLogic #(
  parameter int Xlen = 64
) (
  input  csrPkg::csrOpE    op,
  input  logic [Xlen-1:0]  src,
  input  logic [4:0]       uimm,
  input  logic [Xlen-1:0]  oldVal,
  output logic [Xlen-1:0]  wrData,
  output logic             wrReq
);

  logic [Xlen-1:0] operand;

  // Immediate forms take the zero-extended uimm
  assign operand = op[2] ? Xlen'(uimm) : src;

  always_comb begin
    unique case (op)
      csrPkg::OpRw, csrPkg::OpRwi: begin
        wrData = operand;
        wrReq  = 1'b1;
      end
      csrPkg::OpRs, csrPkg::OpRsi: begin
        wrData = oldVal | operand;
        wrReq  = |operand;
      end
      csrPkg::OpRc, csrPkg::OpRci: begin
        wrData = oldVal & ~operand;
        wrReq  = |operand;
      end
      default: begin
        wrData = oldVal;
        wrReq  = 1'b0;
      end
    endcase
  end

  // Write forms must always request a commit
  always_comb begin
    if (op inside {csrPkg::OpRw, csrPkg::OpRwi}) begin
      assert final (wrReq) else $error("csrOpLogic: write op %s without wrReq", op.name());
    end
  end

endmodule

`default_nettype wire

// File: csrPkg.sv
//////////////////////////////
// CSR addresses, opcodes and field masks. Masks are given at
// 32 bits or less and zero-extended by the user to XLEN.
//////////////////////////////
`default_nettype none

package csrPkg;

  // Supported CSR addresses
  typedef enum logic [11:0] {
    AddrSstatus    = 12'h100,
    AddrSie        = 12'h104,
    AddrStvec      = 12'h105,
    AddrScounteren = 12'h106,
    AddrSenvcfg    = 12'h10A,
    AddrSscratch   = 12'h140,
    AddrSepc       = 12'h141,
    AddrScause     = 12'h142,
    AddrStval      = 12'h143,
    AddrSip        = 12'h144,
    AddrStimecmp   = 12'h14D,
    AddrStimecmph  = 12'h15D,
    AddrSatp       = 12'h180,
    AddrMstatus    = 12'h300,
    AddrMideleg    = 12'h303,
    AddrMie        = 12'h304,
    AddrMenvcfg    = 12'h30A,
    AddrMenvcfgh   = 12'h31A,
    AddrMip        = 12'h344,
    // Custom machine read-only slot for the timer
    AddrMtime      = 12'hFC0
  } csrAddrE;

  // Opcodes follow the funct3 encoding, bit 2 selects the immediate
  typedef enum logic [2:0] {
    OpRw  = 3'b001,
    OpRs  = 3'b010,
    OpRc  = 3'b011,
    OpRwi = 3'b101,
    OpRsi = 3'b110,
    OpRci = 3'b111
  } csrOpE;

  localparam logic [11:0] SupIntMask  = 12'h222;
  localparam logic [11:0] MieMask     = 12'hAAA;
  localparam int          StipIdx     = 5;
  // SUM, MXR and TVM
  localparam logic [31:0] MstatusMask = 32'h001C_0000;
  localparam logic [31:0] SstatusMask = 32'h000C_0000;
  localparam int          TvmIdx      = 20;
  localparam logic [7:0]  SenvcfgMask = 8'hF1;

endpackage

`default_nettype wire

// File: csrUnit.sv
//////////////////////////////
// One access per cycle, no back-pressure. Old value is returned
// at once and the new value commits at the next clock edge.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csrUnit #(
  parameter int Xlen = 64
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        csrValid,
  input  csrPkg::csrOpE               csrOp,
  input  logic [11:0]                 csrAddr,
  input  logic [Xlen-1:0]             srcVal,
  input  logic [4:0]                  uimm,
  input  privPkg::privModeE           privMode,
  input  logic                        trapToS,
  input  logic [Xlen-1:0]             trapEpc,
  input  logic [privPkg::CauseW-1:0]  trapCause,
  input  logic [Xlen-1:0]             trapTval,
  output logic [Xlen-1:0]             readVal,
  output logic                        illegal,
  output logic                        sTimerInt,
  output logic [Xlen-1:0]             satp
);

  csrPkg::csrAddrE addr;
  logic            mBank, privLow, roWrite, wrReq, wrAllowed;
  logic            mWrEn, sWrEn, mIllegal, sIllegal;
  logic [Xlen-1:0] mReadVal, sReadVal, bankReadVal, wrData, sstatus;
  logic            tvm, stce;
  logic [11:0]     mip, mie, mideleg;
  logic [63:0]     mtime;

  ////////////////////////////////
  // Address decode
  ////////////////////////////////
  assign addr    = csrPkg::csrAddrE'(csrAddr);
  // Bits 9:8 hold the lowest privilege allowed
  assign privLow = privMode < csrAddr[9:8];
  assign roWrite = (csrAddr[11:10] == 2'b11) & wrReq;
  assign mBank   = (csrAddr[9:8] == 2'b11);

  assign bankReadVal = mBank ? mReadVal : sReadVal;
  assign illegal     = privLow | roWrite | (mBank ? mIllegal : sIllegal);
  assign readVal     = illegal ? '0 : bankReadVal;

  assign wrAllowed = csrValid & wrReq & ~illegal;
  assign mWrEn     = wrAllowed & mBank;
  assign sWrEn     = wrAllowed & ~mBank;

  csrOpLogic #(.Xlen(Xlen)) i_csrOpLogic (
    .op     (csrOp),
    .src    (srcVal),
    .uimm   (uimm),
    .oldVal (bankReadVal),
    .wrData (wrData),
    .wrReq  (wrReq)
  );

  machineCsrs #(.Xlen(Xlen)) i_machineCsrs (
    .clk         (clk),
    .rstN        (rstN),
    .wrEn        (mWrEn),
    .addr        (addr),
    .wrData      (wrData),
    .sTimerInt   (sTimerInt),
    .readVal     (mReadVal),
    .illegalAddr (mIllegal),
    .tvm         (tvm),
    .stce        (stce),
    .sstatus     (sstatus),
    .mip         (mip),
    .mie         (mie),
    .mideleg     (mideleg),
    .mtime       (mtime)
  );

  supervisorCsrs #(.Xlen(Xlen)) i_supervisorCsrs (
    .clk         (clk),
    .rstN        (rstN),
    .wrEn        (sWrEn),
    .addr        (addr),
    .wrData      (wrData),
    .trapToS     (trapToS),
    .trapEpc     (trapEpc),
    .trapCause   (trapCause),
    .trapTval    (trapTval),
    .privMode    (privMode),
    .tvm         (tvm),
    .stce        (stce),
    .sstatus     (sstatus),
    .mip         (mip),
    .mie         (mie),
    .mideleg     (mideleg),
    .mtime       (mtime),
    .readVal     (sReadVal),
    .illegalAddr (sIllegal),
    .sTimerInt   (sTimerInt),
    .satp        (satp)
  );

  // An illegal access must not reach either bank
  assert property (@(posedge clk) disable iff (!rstN) illegal |-> !(mWrEn || sWrEn))
    else $error("csrUnit: bank write strobe during illegal access");

endmodule

`default_nettype wire

// File: machineCsrs.sv
//////////////////////////////
// Only SUM, MXR, TVM and STCE are kept. mtime reads its low XLEN
// bits and cannot be written.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module machineCsrs #(
  parameter int Xlen = 64
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             wrEn,
  input  csrPkg::csrAddrE  addr,
  input  logic [Xlen-1:0]  wrData,
  input  logic             sTimerInt,
  output logic [Xlen-1:0]  readVal,
  output logic             illegalAddr,
  output logic             tvm,
  output logic             stce,
  output logic [Xlen-1:0]  sstatus,
  output logic [11:0]      mip,
  output logic [11:0]      mie,
  output logic [11:0]      mideleg,
  output logic [63:0]      mtime
);

  logic [Xlen-1:0] mstatus;
  // Software-writable SSIP and SEIP bits of mip
  logic [11:0]     mipSw;
  logic            wrStce;

  // STCE is bit 63 of menvcfg and sits in menvcfgh at XLEN 32
  assign wrStce = wrEn & ((Xlen == 64) ? (addr == csrPkg::AddrMenvcfg)
                                       : (addr == csrPkg::AddrMenvcfgh));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mstatus <= '0;
      mipSw   <= '0;
      mie     <= '0;
      mideleg <= '0;
      stce    <= 1'b0;
      mtime   <= '0;
    end else begin
      mtime <= mtime + 64'd1;
      if (wrEn && addr == csrPkg::AddrMstatus) begin
        mstatus <= wrData & Xlen'(csrPkg::MstatusMask);
      end
      if (wrEn && addr == csrPkg::AddrMip) begin
        mipSw <= wrData[11:0] & csrPkg::SupIntMask & ~(12'd1 << csrPkg::StipIdx);
      end
      if (wrEn && addr == csrPkg::AddrMie) begin
        mie <= wrData[11:0] & csrPkg::MieMask;
      end
      if (wrEn && addr == csrPkg::AddrMideleg) begin
        mideleg <= wrData[11:0] & csrPkg::SupIntMask;
      end
      if (wrStce) begin
        stce <= wrData[Xlen-1];
      end
    end
  end

  ////////////////////////////////
  // Views for the supervisor bank
  ////////////////////////////////
  assign tvm     = mstatus[csrPkg::TvmIdx];
  assign sstatus = mstatus & Xlen'(csrPkg::SstatusMask);

  // STIP comes only from the stimecmp compare
  always_comb begin
    mip                  = mipSw;
    mip[csrPkg::StipIdx] = sTimerInt;
  end

  always_comb begin
    illegalAddr = 1'b0;
    readVal     = '0;
    case (addr)
      csrPkg::AddrMstatus:  readVal = mstatus;
      csrPkg::AddrMip:      readVal = Xlen'(mip);
      csrPkg::AddrMie:      readVal = Xlen'(mie);
      csrPkg::AddrMideleg:  readVal = Xlen'(mideleg);
      csrPkg::AddrMenvcfg: begin
        if (Xlen == 64) begin
          readVal[Xlen-1] = stce;
        end
      end
      csrPkg::AddrMenvcfgh: begin
        if (Xlen == 32) begin
          readVal[Xlen-1] = stce;
        end else begin
          illegalAddr = 1'b1;
        end
      end
      csrPkg::AddrMtime:    readVal = mtime[Xlen-1:0];
      default:              illegalAddr = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: privPkg.sv
//////////////////////////////
// Privilege modes, trap cause width and satp mode codes.
//////////////////////////////
`default_nettype none

package privPkg;

  // Hypervisor mode is not modeled
  typedef enum logic [1:0] {
    PrivU = 2'b00,
    PrivS = 2'b01,
    PrivM = 2'b11
  } privModeE;

  // Top bit is the interrupt flag, low four bits the code
  localparam int CauseW = 5;

  // satp MODE field codes, used at XLEN 64 only
  localparam logic [3:0] SatpBare = 4'd0;
  localparam logic [3:0] SatpSv39 = 4'd8;
  localparam logic [3:0] SatpSv48 = 4'd9;

endpackage

`default_nettype wire

// File: supervisorCsrs.sv
//////////////////////////////
// sstatus, sip and sie are read-only views here; their bits are
// written through the machine bank.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module supervisorCsrs #(
  parameter int Xlen = 64
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        wrEn,
  input  csrPkg::csrAddrE             addr,
  input  logic [Xlen-1:0]             wrData,
  input  logic                        trapToS,
  input  logic [Xlen-1:0]             trapEpc,
  input  logic [privPkg::CauseW-1:0]  trapCause,
  input  logic [Xlen-1:0]             trapTval,
  input  privPkg::privModeE           privMode,
  input  logic                        tvm,
  input  logic                        stce,
  input  logic [Xlen-1:0]             sstatus,
  input  logic [11:0]                 mip,
  input  logic [11:0]                 mie,
  input  logic [11:0]                 mideleg,
  input  logic [63:0]                 mtime,
  output logic [Xlen-1:0]             readVal,
  output logic                        illegalAddr,
  output logic                        sTimerInt,
  output logic [Xlen-1:0]             satp
);

  logic [Xlen-1:0] stvec, sscratch, sepc, scause, stval, senvcfg;
  logic [31:0]     scounteren;
  logic [63:0]     stimecmp;
  logic [Xlen-1:0] causeNext;
  logic            satpAccessOk, satpModeOk;
  logic            wrSatp, wrStimecmp, wrStimecmph;

  ////////////////////////////////
  // Write qualification
  ////////////////////////////////
  assign satpAccessOk = (privMode == privPkg::PrivM) | ~tvm;
  // Bare, Sv39 and Sv48 only
  assign satpModeOk   = (Xlen != 64) ||
                        (wrData[Xlen-1 -: 4] inside {privPkg::SatpBare, privPkg::SatpSv39,
                                                     privPkg::SatpSv48});
  assign wrSatp       = wrEn & (addr == csrPkg::AddrSatp) & satpAccessOk & satpModeOk;
  assign wrStimecmp   = wrEn & (addr == csrPkg::AddrStimecmp) & stce;
  assign wrStimecmph  = wrEn & (addr == csrPkg::AddrStimecmph) & stce & (Xlen == 32);

  // Interrupt flag goes to the top bit, code stays in the low nibble
  assign causeNext = trapToS ? {trapCause[4], {(Xlen-5){1'b0}}, trapCause[3:0]}
                             : {wrData[Xlen-1], {(Xlen-5){1'b0}}, wrData[3:0]};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stvec      <= '0;
      sscratch   <= '0;
      sepc       <= '0;
      scause     <= '0;
      stval      <= '0;
      satp       <= '0;
      scounteren <= '0;
      senvcfg    <= '0;
      stimecmp   <= '0;
    end else begin
      if (wrEn && addr == csrPkg::AddrStvec) begin
        stvec <= {wrData[Xlen-1:2], 1'b0, wrData[0]};
      end
      if (wrEn && addr == csrPkg::AddrSscratch) begin
        sscratch <= wrData;
      end
      // Trap wins over a CSR write in the same cycle
      if (trapToS || (wrEn && addr == csrPkg::AddrSepc)) begin
        sepc <= trapToS ? trapEpc : wrData;
      end
      if (trapToS || (wrEn && addr == csrPkg::AddrScause)) begin
        scause <= causeNext;
      end
      if (trapToS || (wrEn && addr == csrPkg::AddrStval)) begin
        stval <= trapToS ? trapTval : wrData;
      end
      if (wrSatp) begin
        satp <= wrData;
      end
      if (wrEn && addr == csrPkg::AddrScounteren) begin
        scounteren <= wrData[31:0];
      end
      if (wrEn && addr == csrPkg::AddrSenvcfg) begin
        senvcfg <= Xlen'(wrData[7:0] & csrPkg::SenvcfgMask);
      end
      if (wrStimecmp) begin
        if (Xlen == 64) begin
          stimecmp <= 64'(wrData);
        end else begin
          stimecmp[31:0] <= wrData[31:0];
        end
      end
      if (wrStimecmph) begin
        stimecmp[63:32] <= wrData[31:0];
      end
    end
  end

  // Unsigned compare, live in the cycle after a stimecmp write
  assign sTimerInt = (mtime >= stimecmp);

  ////////////////////////////////
  // Read mux and access checks
  ////////////////////////////////
  always_comb begin
    illegalAddr = 1'b0;
    readVal     = '0;
    case (addr)
      csrPkg::AddrSstatus:    readVal = sstatus;
      csrPkg::AddrStvec:      readVal = stvec;
      // Only delegated supervisor bits are visible
      csrPkg::AddrSip:        readVal = Xlen'(mip & csrPkg::SupIntMask & mideleg);
      csrPkg::AddrSie:        readVal = Xlen'(mie & csrPkg::SupIntMask & mideleg);
      csrPkg::AddrSscratch:   readVal = sscratch;
      csrPkg::AddrSepc:       readVal = sepc;
      csrPkg::AddrScause:     readVal = scause;
      csrPkg::AddrStval:      readVal = stval;
      csrPkg::AddrScounteren: readVal = Xlen'(scounteren);
      csrPkg::AddrSenvcfg:    readVal = senvcfg;
      csrPkg::AddrSatp: begin
        if (satpAccessOk) readVal = satp;
        else illegalAddr = 1'b1;
      end
      csrPkg::AddrStimecmp: begin
        if (stce) readVal = stimecmp[Xlen-1:0];
        else illegalAddr = 1'b1;
      end
      csrPkg::AddrStimecmph: begin
        if (stce && Xlen == 32) readVal = Xlen'(stimecmp[63:32]);
        else illegalAddr = 1'b1;
      end
      default:                illegalAddr = 1'b1;
    endcase
  end

  // Refused accesses never leak register contents
  assert property (@(posedge clk) disable iff (!rstN) illegalAddr |-> (readVal == '0))
    else $error("supervisorCsrs: nonzero readVal on illegal access");

endmodule

`default_nettype wire

// File: tbCsrUnit.sv
//////////////////////////////
// Runs at XLEN 64 only. Expected values assume mtime stays far
// below all ones for the whole run.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tbCsrUnit;

  localparam int Xlen = 64;

  typedef struct {
    csrPkg::csrOpE     op;
    logic [11:0]       addr;
    logic [Xlen-1:0]   src;
    logic [4:0]        uimm;
    privPkg::privModeE priv;
    bit                trap;
    logic [Xlen-1:0]   expRead;
    bit                expIllegal;
    bit                timerChk;
    bit                expTimer;
    bit                satpChk;
    logic [Xlen-1:0]   expSatp;
  } stepT;

  logic                        clk;
  logic                        rstN;
  logic                        csrValid;
  csrPkg::csrOpE               csrOp;
  logic [11:0]                 csrAddr;
  logic [Xlen-1:0]             srcVal;
  logic [4:0]                  uimm;
  privPkg::privModeE           privMode;
  logic                        trapToS;
  logic [Xlen-1:0]             trapEpc;
  logic [privPkg::CauseW-1:0]  trapCause;
  logic [Xlen-1:0]             trapTval;
  logic [Xlen-1:0]             readVal;
  logic                        illegal;
  logic                        sTimerInt;
  logic [Xlen-1:0]             satp;

  stepT            rows[$];
  int              errors;
  int              checks;
  int              cycles;
  int              cycleLimit;
  logic [Xlen-1:0] d1, d2, d3, epc, tval, satpVal, badSatp, tvmBit, stceBit, causeExp;
  logic [4:0]      cause;

  csrUnit #(.Xlen(Xlen)) i_csrUnit (
    .clk       (clk),
    .rstN      (rstN),
    .csrValid  (csrValid),
    .csrOp     (csrOp),
    .csrAddr   (csrAddr),
    .srcVal    (srcVal),
    .uimm      (uimm),
    .privMode  (privMode),
    .trapToS   (trapToS),
    .trapEpc   (trapEpc),
    .trapCause (trapCause),
    .trapTval  (trapTval),
    .readVal   (readVal),
    .illegal   (illegal),
    .sTimerInt (sTimerInt),
    .satp      (satp)
  );

  always #5 clk = ~clk;

  // Run limit grows with the table
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycleLimit != 0 && cycles >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////
  // Compare tasks
  ////////////////////////////////
  task checkData(input string name, input int row, input logic [Xlen-1:0] got,
                 input logic [Xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t row %0d %s got %h expected %h", $time, row, name, got, exp);
    end
  endtask

  task checkFlag(input string name, input int row, input logic got, input bit exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t row %0d %s got %b expected %b", $time, row, name, got, exp);
    end
  endtask

  ////////////////////////////////
  // Table building
  ////////////////////////////////
  task addAccess(input csrPkg::csrOpE op, input logic [11:0] addr, input logic [Xlen-1:0] src,
                 input logic [4:0] imm, input privPkg::privModeE priv,
                 input logic [Xlen-1:0] expRead, input bit expIllegal);
    stepT s;
    s.op         = op;
    s.addr       = addr;
    s.src        = src;
    s.uimm       = imm;
    s.priv       = priv;
    s.trap       = 1'b0;
    s.expRead    = expRead;
    s.expIllegal = expIllegal;
    s.timerChk   = 1'b0;
    s.expTimer   = 1'b0;
    s.satpChk    = 1'b0;
    s.expSatp    = '0;
    rows.push_back(s);
  endtask

  // Applies to the row added last
  task expectTimer(input bit level);
    rows[rows.size()-1].timerChk = 1'b1;
    rows[rows.size()-1].expTimer = level;
  endtask

  // Satp output level seen in the row added last
  task expectSatp(input logic [Xlen-1:0] value);
    rows[rows.size()-1].satpChk = 1'b1;
    rows[rows.size()-1].expSatp = value;
  endtask

  task buildTable;
    d1      = Xlen'({$urandom, $urandom});
    d2      = Xlen'({$urandom, $urandom});
    d3      = Xlen'({$urandom, $urandom});
    epc     = Xlen'({$urandom, $urandom});
    tval    = Xlen'({$urandom, $urandom});
    // Interrupt cause with a random code
    cause   = 5'($urandom) | 5'h10;
    tvmBit  = '0;
    tvmBit[20] = 1'b1;
    stceBit = '0;
    stceBit[Xlen-1] = 1'b1;
    satpVal = {4'd8, d2[Xlen-5:0]};
    badSatp = {4'd5, d3[Xlen-5:0]};
    // Interrupt flag in the top bit and code in the low nibble
    causeExp = Xlen'(cause[3:0]);
    causeExp[Xlen-1] = cause[4];

    // sscratch write, set and clear
    addAccess(csrPkg::OpRw, csrPkg::AddrSscratch, d1, 5'd0, privPkg::PrivS, '0, 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrSscratch, d2, 5'd0, privPkg::PrivS, d1, 1'b0);
    addAccess(csrPkg::OpRc, csrPkg::AddrSscratch, d3, 5'd0, privPkg::PrivS, d1 | d2, 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrSscratch, '0, 5'd0, privPkg::PrivS,
              (d1 | d2) & ~d3, 1'b0);
    addAccess(csrPkg::OpRsi, csrPkg::AddrSscratch, '0, 5'd0, privPkg::PrivS,
              (d1 | d2) & ~d3, 1'b0);
    addAccess(csrPkg::OpRwi, csrPkg::AddrSscratch, '0, 5'h1A, privPkg::PrivS,
              (d1 | d2) & ~d3, 1'b0);
    addAccess(csrPkg::OpRci, csrPkg::AddrSscratch, '0, 5'h0A, privPkg::PrivS,
              Xlen'(8'h1A), 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrSscratch, '0, 5'd0, privPkg::PrivS,
              Xlen'(8'h10), 1'b0);

    // Field masks
    addAccess(csrPkg::OpRw, csrPkg::AddrStvec, d1, 5'd0, privPkg::PrivS, '0, 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrStvec, '0, 5'd0, privPkg::PrivS,
              d1 & ~Xlen'(2'b10), 1'b0);
    addAccess(csrPkg::OpRw, csrPkg::AddrSenvcfg, d2, 5'd0, privPkg::PrivS, '0, 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrSenvcfg, '0, 5'd0, privPkg::PrivS,
              d2 & Xlen'(8'hF1), 1'b0);
    addAccess(csrPkg::OpRw, csrPkg::AddrMie, d3, 5'd0, privPkg::PrivM, '0, 1'b0);
    addAccess(csrPkg::OpRw, csrPkg::AddrMideleg, '1, 5'd0, privPkg::PrivM, '0, 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrMideleg, '0, 5'd0, privPkg::PrivM,
              Xlen'(12'h222), 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrSie, '0, 5'd0, privPkg::PrivS,
              Xlen'(d3[11:0] & 12'h222), 1'b0);
    // STIP is set since stimecmp resets to zero
    addAccess(csrPkg::OpRw, csrPkg::AddrMip, Xlen'(4'h2), 5'd0, privPkg::PrivM,
              Xlen'(12'h020), 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrSip, '0, 5'd0, privPkg::PrivS, Xlen'(12'h022), 1'b0);
    addAccess(csrPkg::OpRc, csrPkg::AddrMideleg, Xlen'(12'h020), 5'd0, privPkg::PrivM,
              Xlen'(12'h222), 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrSip, '0, 5'd0, privPkg::PrivS, Xlen'(12'h002), 1'b0);

    // Privilege and legality
    addAccess(csrPkg::OpRw, csrPkg::AddrMideleg, '0, 5'd0, privPkg::PrivS, '0, 1'b1);
    addAccess(csrPkg::OpRs, csrPkg::AddrMideleg, '0, 5'd0, privPkg::PrivM,
              Xlen'(12'h202), 1'b0);
    addAccess(csrPkg::OpRw, csrPkg::AddrMtime, d2, 5'd0, privPkg::PrivM, '0, 1'b1);
    addAccess(csrPkg::OpRs, 12'h150, '0, 5'd0, privPkg::PrivS, '0, 1'b1);
    addAccess(csrPkg::OpRw, csrPkg::AddrMstatus, tvmBit, 5'd0, privPkg::PrivM, '0, 1'b0);
    addAccess(csrPkg::OpRw, csrPkg::AddrSatp, satpVal, 5'd0, privPkg::PrivS, '0, 1'b1);
    addAccess(csrPkg::OpRs, csrPkg::AddrSatp, '0, 5'd0, privPkg::PrivM, '0, 1'b0);
    expectSatp('0);
    addAccess(csrPkg::OpRc, csrPkg::AddrMstatus, tvmBit, 5'd0, privPkg::PrivM, tvmBit, 1'b0);
    addAccess(csrPkg::OpRw, csrPkg::AddrSatp, satpVal, 5'd0, privPkg::PrivS, '0, 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrSatp, '0, 5'd0, privPkg::PrivS, satpVal, 1'b0);
    expectSatp(satpVal);
    addAccess(csrPkg::OpRw, csrPkg::AddrSatp, badSatp, 5'd0, privPkg::PrivS, satpVal, 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrSatp, '0, 5'd0, privPkg::PrivS, satpVal, 1'b0);
    expectSatp(satpVal);

    // Trap pulse, then read back
    addAccess(csrPkg::OpRs, csrPkg::AddrSepc, '0, 5'd0, privPkg::PrivS, '0, 1'b0);
    rows[rows.size()-1].trap = 1'b1;
    addAccess(csrPkg::OpRs, csrPkg::AddrSepc, '0, 5'd0, privPkg::PrivS, epc, 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrScause, '0, 5'd0, privPkg::PrivS, causeExp, 1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrStval, '0, 5'd0, privPkg::PrivS, tval, 1'b0);

    // Supervisor timer
    addAccess(csrPkg::OpRs, csrPkg::AddrStimecmp, '0, 5'd0, privPkg::PrivS, '0, 1'b1);
    addAccess(csrPkg::OpRw, csrPkg::AddrMenvcfg, stceBit, 5'd0, privPkg::PrivM, '0, 1'b0);
    addAccess(csrPkg::OpRw, csrPkg::AddrStimecmp, '1, 5'd0, privPkg::PrivS, '0, 1'b0);
    expectTimer(1'b1);
    addAccess(csrPkg::OpRs, csrPkg::AddrStimecmp, '0, 5'd0, privPkg::PrivS, '1, 1'b0);
    expectTimer(1'b0);
    addAccess(csrPkg::OpRw, csrPkg::AddrStimecmp, '0, 5'd0, privPkg::PrivS, '1, 1'b0);
    expectTimer(1'b0);
    addAccess(csrPkg::OpRs, csrPkg::AddrMip, '0, 5'd0, privPkg::PrivM, Xlen'(12'h022), 1'b0);
    expectTimer(1'b1);
    // High half exists only at XLEN 32
    addAccess(csrPkg::OpRs, csrPkg::AddrStimecmph, '0, 5'd0, privPkg::PrivS, '0, 1'b1);
  endtask

  ////////////////////////////////
  // Main sequence
  ////////////////////////////////
  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    csrValid   = 1'b0;
    csrOp      = csrPkg::OpRs;
    csrAddr    = '0;
    srcVal     = '0;
    uimm       = '0;
    privMode   = privPkg::PrivM;
    trapToS    = 1'b0;
    trapEpc    = '0;
    trapCause  = '0;
    trapTval   = '0;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    cycleLimit = 0;

    void'($urandom(39804));
    buildTable();
    cycleLimit = rows.size() * 4 + 50;
    trapEpc    = epc;
    trapCause  = cause;
    trapTval   = tval;

    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      csrValid <= 1'b1;
      csrOp    <= rows[i].op;
      csrAddr  <= rows[i].addr;
      srcVal   <= rows[i].src;
      uimm     <= rows[i].uimm;
      privMode <= rows[i].priv;
      trapToS  <= rows[i].trap;
      @(negedge clk);
      checkData("readVal", i, readVal, rows[i].expRead);
      checkFlag("illegal", i, illegal, rows[i].expIllegal);
      if (rows[i].timerChk) begin
        checkFlag("sTimerInt", i, sTimerInt, rows[i].expTimer);
      end
      if (rows[i].satpChk) begin
        checkData("satp", i, satp, rows[i].expSatp);
      end
    end

    @(posedge clk);
    csrValid <= 1'b0;
    trapToS  <= 1'b0;
    @(posedge clk);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
csrPkg.sv
privPkg.sv
csrOpLogic.sv
machineCsrs.sv
supervisorCsrs.sv
csrUnit.sv
tbCsrUnit.sv
